/* hdl/letterPkg.sv */
package letterPkg;

    localparam int wordLen = 5;

    typedef logic [7:0] letter_t; // ascii, 0 means no guess

    localparam letter_t blankChar = 8'h5F; // '_'
    localparam letter_t asciiA = 8'h41;

    // position 0 is the leftmost byte
    typedef letter_t [0:wordLen-1] word_t;

    typedef struct packed {
        word_t shown;
        logic [2:0] livesLeft;
    } display_t;

endpackage

/* hdl/gamePkg.sv */
package gamePkg;

    localparam int maxMisses = 6;

    // L0..L4 must stay consecutive, the matcher steps through them by +1
    typedef enum logic [3:0] {
        SET,
        FIRST,
        L0,
        L1,
        L2,
        L3,
        L4,
        STOP,
        IDLE
    } matchState_t;

    typedef struct packed {
        logic [2:0] correct;
        logic [2:0] incorrect;
        logic [letterPkg::wordLen-1:0] found; // bit 4 is position 0
        logic win;
        logic lose;
    } gameStatus_t;

endpackage

/* hdl/wordLoader.sv */
`timescale 1ns/1ps

module wordLoader (
    input logic clk,
    input logic nRst,
    input letterPkg::letter_t hostLetter,
    input logic hostStrobe,
    input logic startGame,
    input logic lockWord,
    output letterPkg::word_t secretWord,
    output logic armGame
);
    import letterPkg::*;

    logic [2:0] fillCount;
    logic wordFull;

    assign wordFull = (fillCount == wordLen);

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            secretWord <= '0;
            fillCount <= '0;
            armGame <= 1'b0;
        end else begin
            armGame <= startGame && wordFull && !lockWord;
            if (!lockWord) begin
                if (startGame && wordFull) begin
                    fillCount <= '0; // next game needs a fresh word
                end else if (hostStrobe) begin
                    secretWord <= {secretWord[1:wordLen-1], hostLetter}; // shift in at low byte
                    if (!wordFull) begin
                        fillCount <= fillCount + 3'd1;
                    end
                end
            end
        end
    end

    // arming only ever follows a complete word
    armOnlyWhenFull: assert property (
        @(posedge clk) disable iff (!nRst)
        $rose(armGame) |-> $past(fillCount) == wordLen
    ) else $error("armGame raised with a partial word");

endmodule

/* hdl/guessEncoder.sv */
`timescale 1ns/1ps

module guessEncoder (
    input logic clk,
    input logic nRst,
    input logic [25:0] keys,
    output letterPkg::letter_t guess
);
    import letterPkg::*;

    logic [25:0] keysPrev;
    logic [25:0] rising;
    letter_t nextGuess;

    assign rising = keys & ~keysPrev;

    // lowest index wins, so scan downward and let it overwrite last
    always_comb begin
        nextGuess = '0;
        for (int i = 25; i >= 0; i--) begin
            if (rising[i]) begin
                nextGuess = asciiA + letter_t'(i);
            end
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            keysPrev <= '0;
            guess <= '0;
        end else begin
            keysPrev <= keys;
            guess <= nextGuess; // one cycle per press
        end
    end

    guessIsLetter: assert property (
        @(posedge clk) disable iff (!nRst)
        guess inside {8'h00, [asciiA:asciiA + 8'd25]}
    ) else $error("guess code %h is not A-Z", guess);

endmodule

/* hdl/guessMatcher.sv */
`timescale 1ns/1ps

module guessMatcher (
    input logic clk,
    input logic nRst,
    input letterPkg::letter_t guess,
    input letterPkg::word_t secretWord,
    input logic armGame,
    input logic newGame,
    output gamePkg::gameStatus_t status,
    output logic mistake,
    output logic busy,
    output logic ready,
    output logic lockWord
);
    import letterPkg::*;
    import gamePkg::*;

    matchState_t state;
    matchState_t nextState;
    gameStatus_t nextStatus;
    letter_t letter;
    letter_t nextLetter;
    logic [wordLen-1:0] hitMask;
    logic [wordLen-1:0] nextHitMask;
    logic [2:0] hitCount;
    logic [2:0] nextHitCount;
    logic [2:0] pos;
    logic [2:0] revealBit;
    logic gameOver;

    assign pos = 3'(state - L0); // valid in L0..L4 only
    assign revealBit = 3'(wordLen - 1) - pos;
    assign gameOver = (status.correct == wordLen) || (status.incorrect == maxMisses);

    assign busy = (state inside {L0, L1, L2, L3, L4});
    assign ready = (state == FIRST) || (state == IDLE);
    assign lockWord = (state != SET);

    always_comb begin
        nextState = state;
        nextStatus = status;
        nextLetter = letter;
        nextHitMask = hitMask;
        nextHitCount = hitCount;
        mistake = 1'b0;

        case (state)
            SET: begin
                nextStatus = '0;
                if (armGame) begin
                    nextState = FIRST;
                end
            end
            FIRST, IDLE: begin
                if (state == IDLE) begin
                    if (status.correct == wordLen) begin
                        nextStatus.win = 1'b1;
                    end else if (status.incorrect == maxMisses) begin
                        nextStatus.lose = 1'b1;
                    end
                end
                if (state == IDLE && newGame) begin
                    nextStatus = '0;
                    nextState = SET;
                end else if (guess != '0 && !gameOver) begin
                    nextLetter = guess;
                    nextHitMask = '0;
                    nextHitCount = '0;
                    nextState = L0;
                end
            end
            L0, L1, L2, L3, L4: begin
                // already revealed positions do not score again
                if (secretWord[pos] == letter && !status.found[revealBit]) begin
                    nextHitMask[revealBit] = 1'b1;
                    nextHitCount = hitCount + 3'd1;
                end
                nextState = matchState_t'(state + 4'd1); // L4 steps into STOP
            end
            STOP: begin
                if (hitCount != '0) begin
                    nextStatus.found = status.found | hitMask;
                    nextStatus.correct = status.correct + hitCount;
                end else begin
                    mistake = 1'b1;
                    nextStatus.incorrect = status.incorrect + 3'd1;
                end
                nextState = IDLE;
            end
            default: begin
                nextState = SET;
            end
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state <= SET;
            status <= '0;
            hitMask <= '0;
            hitCount <= '0;
        end else begin
            state <= nextState;
            status <= nextStatus;
            hitMask <= nextHitMask;
            hitCount <= nextHitCount;
        end
    end

    always_ff @(posedge clk) begin
        letter <= nextLetter;
    end

    correctInRange: assert property (
        @(posedge clk) disable iff (!nRst)
        status.correct <= wordLen
    ) else $error("correct count overflow");

    missesInRange: assert property (
        @(posedge clk) disable iff (!nRst)
        status.incorrect <= maxMisses
    ) else $error("incorrect count overflow");

    notBusyAndReady: assert property (
        @(posedge clk) disable iff (!nRst)
        !(busy && ready)
    ) else $error("busy and ready both high");

endmodule

/* hdl/statusDisplay.sv */
`timescale 1ns/1ps

module statusDisplay (
    input logic clk,
    input logic nRst,
    input letterPkg::word_t secretWord,
    input gamePkg::gameStatus_t status,
    output letterPkg::display_t display
);
    import letterPkg::*;
    import gamePkg::*;

    display_t nextDisplay;

    always_comb begin
        nextDisplay.livesLeft = 3'(maxMisses) - status.incorrect;
        for (int i = 0; i < wordLen; i++) begin
            // found bits run opposite to positions
            if (status.found[wordLen-1-i]) begin
                nextDisplay.shown[i] = secretWord[i];
            end else begin
                nextDisplay.shown[i] = blankChar;
            end
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            display <= '{shown: {wordLen{blankChar}}, livesLeft: 3'(maxMisses)};
        end else begin
            display <= nextDisplay; // one cycle behind status
        end
    end

endmodule

/* hdl/hangmanTop.sv */
`timescale 1ns/1ps

module hangmanTop (
    input logic clk,
    input logic nRst,
    input letterPkg::letter_t hostLetter,
    input logic hostStrobe,
    input logic startGame,
    input logic [25:0] keys,
    input logic newGame,
    output gamePkg::gameStatus_t status,
    output letterPkg::display_t display,
    output logic ready,
    output logic busy,
    output logic mistake
);
    import letterPkg::*;

    word_t secretWord;
    letter_t guess;
    logic armGame;
    logic lockWord;

    wordLoader i_wordLoader (
        .clk(clk),
        .nRst(nRst),
        .hostLetter(hostLetter),
        .hostStrobe(hostStrobe),
        .startGame(startGame),
        .lockWord(lockWord),
        .secretWord(secretWord),
        .armGame(armGame)
    );

    guessEncoder i_guessEncoder (
        .clk(clk),
        .nRst(nRst),
        .keys(keys),
        .guess(guess)
    );

    guessMatcher i_guessMatcher (
        .clk(clk),
        .nRst(nRst),
        .guess(guess),
        .secretWord(secretWord),
        .armGame(armGame),
        .newGame(newGame),
        .status(status),
        .mistake(mistake),
        .busy(busy),
        .ready(ready),
        .lockWord(lockWord)
    );

    statusDisplay i_statusDisplay (
        .clk(clk),
        .nRst(nRst),
        .secretWord(secretWord),
        .status(status),
        .display(display)
    );

endmodule

/* tests/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
    parameter int periodNs = 10,
    parameter int resetCycles = 3
) (
    output logic clk,
    output logic nRst
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    initial begin
        nRst = 1'b0;
        repeat (resetCycles) @(posedge clk);
        nRst <= 1'b1; // release on an edge
    end

endmodule

/* tests/hangmanTb.sv */
`timescale 1ns/1ps

module hangmanTb;
    import letterPkg::*;
    import gamePkg::*;

    localparam int clkPeriod = 10;
    localparam int plannedGuesses = 40;
    localparam int limitCycles = 200 * plannedGuesses + 1000;

    typedef struct packed {
        logic [31:0] base; // negedge count when the key went up
        logic miss;
        logic taken; // matcher still accepts guesses
        gameStatus_t st;
        word_t w;
    } pending_t;

    logic clk;
    logic nRst;
    letter_t hostLetter;
    logic hostStrobe;
    logic startGame;
    logic [25:0] keys;
    logic newGame;
    gameStatus_t status;
    display_t display;
    logic ready;
    logic busy;
    logic mistake;

    pending_t pending[$];
    int cycle;
    int errorCount;
    int checkCount;
    int testsRun;
    int testsFailed;
    int errorsAtStart;
    gameStatus_t model;
    word_t curWord;

    clockGen #(.periodNs(clkPeriod), .resetCycles(3)) i_clockGen (.clk(clk), .nRst(nRst));

    hangmanTop i_dut (
        .clk(clk),
        .nRst(nRst),
        .hostLetter(hostLetter),
        .hostStrobe(hostStrobe),
        .startGame(startGame),
        .keys(keys),
        .newGame(newGame),
        .status(status),
        .display(display),
        .ready(ready),
        .busy(busy),
        .mistake(mistake)
    );

    function automatic gameStatus_t predictStatus(word_t w, gameStatus_t s, letter_t g);
        gameStatus_t n;
        int hits;
        n = s;
        hits = 0;
        if (s.correct != wordLen && s.incorrect != maxMisses) begin // finished games ignore keys
            for (int p = 0; p < wordLen; p++) begin
                if (w[p] == g && !s.found[wordLen-1-p]) begin
                    n.found[wordLen-1-p] = 1'b1;
                    hits++;
                end
            end
            if (hits > 0) begin
                n.correct = s.correct + 3'(hits);
            end else begin
                n.incorrect = s.incorrect + 3'd1;
            end
            n.win = (n.correct == wordLen);
            n.lose = (n.incorrect == maxMisses);
        end
        return n;
    endfunction

    function automatic display_t expectDisplay(word_t w, gameStatus_t s);
        display_t d;
        for (int p = 0; p < wordLen; p++) begin
            d.shown[p] = s.found[wordLen-1-p] ? w[p] : blankChar;
        end
        d.livesLeft = 3'(maxMisses - s.incorrect);
        return d;
    endfunction

    function automatic word_t randomWord();
        word_t w;
        for (int p = 0; p < wordLen; p++) begin
            w[p] = asciiA + letter_t'($urandom % 26);
        end
        return w;
    endfunction

    task automatic compareValue(input logic [63:0] actual, input logic [63:0] expected,
                                input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Mismatch at %0t: %s, expected %0h, got %0h", $time, what, expected, actual);
        end
    endtask

    task automatic loadWord(input word_t w, input int count);
        for (int p = 0; p < count; p++) begin
            @(posedge clk);
            hostLetter <= w[p];
            hostStrobe <= 1'b1;
        end
        @(posedge clk);
        hostStrobe <= 1'b0;
    endtask

    task automatic pulseStart();
        @(posedge clk);
        startGame <= 1'b1;
        @(posedge clk);
        startGame <= 1'b0;
    endtask

    task automatic waitReady();
        @(negedge clk);
        while (!ready) @(negedge clk);
    endtask

    task automatic drainChecks();
        while (pending.size() != 0) @(negedge clk);
    endtask

    task automatic pressLetter(input letter_t l);
        pending_t entry;
        int idx;
        idx = l - asciiA;
        waitReady();
        @(posedge clk);
        keys <= keys | (26'd1 << idx);
        entry.base = cycle;
        entry.taken = (model.correct != wordLen && model.incorrect != maxMisses);
        entry.st = predictStatus(curWord, model, l);
        entry.miss = (entry.st.incorrect != model.incorrect);
        entry.w = curWord;
        model = entry.st;
        pending.push_back(entry);
        repeat (2) @(posedge clk);
        keys <= keys & ~(26'd1 << idx);
    endtask

    task automatic pulseNewGame();
        drainChecks();
        @(posedge clk);
        newGame <= 1'b1;
        @(posedge clk);
        newGame <= 1'b0;
        @(negedge clk);
        model = '0;
        compareValue(status, '0, "status after newGame");
        compareValue(ready, 1'b0, "ready after newGame");
    endtask

    task automatic beginTest();
        errorsAtStart = errorCount;
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (errorCount != errorsAtStart) begin
            testsFailed++;
            $display("test %0d %s: %0d mismatches", testsRun, name, errorCount - errorsAtStart);
        end else begin
            $display("test %0d %s: ok", testsRun, name);
        end
    endtask

    // offsets count negedges from the cycle the key went up
    initial begin
        pending_t head;
        cycle = 0;
        forever begin
            @(negedge clk);
            cycle++;
            if (pending.size() != 0) begin
                head = pending[0];
                if (cycle >= head.base + 3 && cycle <= head.base + 7) begin
                    compareValue(busy, head.taken, "busy while matching");
                end
                if (cycle == head.base + 8) begin
                    compareValue(mistake, head.miss, "mistake pulse");
                    compareValue(busy, 1'b0, "busy after matching");
                end
                if (cycle == head.base + 9) begin
                    compareValue(status.correct, head.st.correct, "correct count");
                    compareValue(status.incorrect, head.st.incorrect, "incorrect count");
                    compareValue(status.found, head.st.found, "found bits");
                end
                if (cycle == head.base + 10) begin
                    compareValue(status.win, head.st.win, "win flag");
                    compareValue(status.lose, head.st.lose, "lose flag");
                    compareValue(display, expectDisplay(head.w, head.st), "display");
                    head = pending.pop_front();
                end
            end
        end
    end

    initial begin
        #(limitCycles * clkPeriod);
        $display("Timeout: the run did not finish within %0d cycles", limitCycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        logic seen;
        void'($urandom(53998));
        hostLetter = '0;
        hostStrobe = 1'b0;
        startGame = 1'b0;
        keys = '0;
        newGame = 1'b0;
        errorCount = 0;
        checkCount = 0;
        testsRun = 0;
        testsFailed = 0;
        model = '0;
        curWord = '0;
        wait (nRst === 1'b1);
        @(posedge clk);

        beginTest();
        loadWord("GRAPE", 3);
        pulseStart(); // short word is ignored
        repeat (4) begin
            @(negedge clk);
            compareValue(ready, 1'b0, "ready after short word");
        end
        curWord = "LEVEL";
        loadWord(curWord, wordLen);
        pulseStart();
        waitReady();
        compareValue(status, '0, "status after arming");
        compareValue(display, expectDisplay(curWord, '0), "display after arming");
        endTest("loading and arming");

        beginTest();
        pressLetter("E");
        pressLetter("L");
        drainChecks();
        compareValue(status.found, 5'b11011, "found after E and L");
        endTest("correct letters and duplicates");

        beginTest();
        pressLetter("Z");
        pressLetter("E"); // already revealed
        drainChecks();
        compareValue(status.incorrect, 3'd2, "misses after Z and repeat");
        compareValue(display.livesLeft, 3'd4, "lives after two misses");
        endTest("misses and repeats");

        beginTest();
        pulseNewGame();
        curWord = randomWord();
        loadWord(curWord, wordLen);
        pulseStart();
        for (int p = 0; p < wordLen; p++) begin
            seen = 1'b0;
            for (int q = 0; q < p; q++) begin
                if (curWord[q] == curWord[p]) begin
                    seen = 1'b1;
                end
            end
            if (!seen) begin
                pressLetter(curWord[p]);
            end
        end
        drainChecks();
        compareValue(status.win, 1'b1, "win after all letters");
        compareValue(status.lose, 1'b0, "lose after win");
        pressLetter(asciiA + letter_t'($urandom % 26)); // must change nothing
        drainChecks();
        endTest("win");

        beginTest();
        pulseNewGame();
        curWord = "CRANE";
        loadWord(curWord, wordLen);
        pulseStart();
        pressLetter("Z");
        pressLetter("Q");
        pressLetter("X");
        pressLetter("J");
        pressLetter("K");
        pressLetter("W");
        drainChecks();
        compareValue(status.lose, 1'b1, "lose after six misses");
        compareValue(display.livesLeft, 3'd0, "no lives left");
        pulseNewGame();
        curWord = "MOUSE";
        loadWord(curWord, wordLen);
        pulseStart();
        pressLetter("M");
        pressLetter("O");
        pressLetter("T");
        drainChecks();
        endTest("lose and restart");

        beginTest();
        pulseNewGame();
        curWord = randomWord();
        loadWord(curWord, wordLen);
        pulseStart();
        repeat (16) begin
            pressLetter(asciiA + letter_t'($urandom % 26));
        end
        drainChecks();
        endTest("random game");

        $display("tests run %0d, failed %0d, checks %0d, mismatches %0d",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
hdl/letterPkg.sv
hdl/gamePkg.sv
hdl/wordLoader.sv
hdl/guessEncoder.sv
hdl/guessMatcher.sv
hdl/statusDisplay.sv
hdl/hangmanTop.sv
tests/clockGen.sv
tests/hangmanTb.sv

/* Bender.yml */
package:
  name: hangman

sources:
  - files:
      - hdl/letterPkg.sv
      - hdl/gamePkg.sv
      - hdl/wordLoader.sv
      - hdl/guessEncoder.sv
      - hdl/guessMatcher.sv
      - hdl/statusDisplay.sv
      - hdl/hangmanTop.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/hangmanTb.sv
